//--- common/dataPkg.sv
// Datapath sizes and condition code bit positions
`default_nettype none

package dataPkg;

    localparam int wordWidth    = 16;
    localparam int regCount     = 8;
    localparam int regAddrWidth = 3;

    // Condition code register
    localparam int flagWidth = 3;
    localparam int zeroBit   = 0;
    localparam int negBit    = 1;
    localparam int carryBit  = 2; // Only ADD ever sets it

endpackage

`default_nettype wire

//--- common/isaPkg.sv
// Instruction set of the execute unit with opcode codes and the two word formats
`default_nettype none

package isaPkg;

    localparam int opcodeWidth = 5;
    localparam int immWidth    = 8;
    localparam int unusedWidth = 5; // Spare bits of the register format

    // Opcode values, anything above opOut decodes as a NOP
    localparam logic [opcodeWidth-1:0] opNop = 5'd0;
    localparam logic [opcodeWidth-1:0] opAdd = 5'd1;
    localparam logic [opcodeWidth-1:0] opSub = 5'd2;
    localparam logic [opcodeWidth-1:0] opAnd = 5'd3;
    localparam logic [opcodeWidth-1:0] opOr  = 5'd4;
    localparam logic [opcodeWidth-1:0] opNot = 5'd5;
    localparam logic [opcodeWidth-1:0] opInc = 5'd6;
    localparam logic [opcodeWidth-1:0] opDec = 5'd7;
    localparam logic [opcodeWidth-1:0] opShl = 5'd8;
    localparam logic [opcodeWidth-1:0] opShr = 5'd9;
    localparam logic [opcodeWidth-1:0] opLdm = 5'd10;
    localparam logic [opcodeWidth-1:0] opIn  = 5'd11;
    localparam logic [opcodeWidth-1:0] opOut = 5'd12;

    // One 16-bit word seen either as a register op or as an immediate op
    typedef union packed {
        struct packed {
            logic [opcodeWidth-1:0]           opcode; // Bits 15..11
            logic [dataPkg::regAddrWidth-1:0] rd;     // Bits 10..8
            logic [dataPkg::regAddrWidth-1:0] rs;     // Bits 7..5
            logic [unusedWidth-1:0]           unused;
        } regFmt;
        struct packed {
            logic [opcodeWidth-1:0]           opcode;
            logic [dataPkg::regAddrWidth-1:0] rd;
            logic [immWidth-1:0]              imm;    // Zero-extended by the decoder
        } immFmt;
    } instrWord;

endpackage

`default_nettype wire

//--- common/aluCtrlIf.sv
// Operation strobes and operands passed from the decoder to the ALU
`default_nettype none

interface aluCtrlIf;

    // One-hot operation strobes
    logic opAdd;
    logic opNot;
    logic opLdm;
    logic opInc;
    logic opDec;
    logic opSub;
    logic opAnd;
    logic opOr;
    logic opShl;
    logic opShr;
    logic opIn;

    logic [dataPkg::wordWidth-1:0] srcVal; // rs or the immediate
    logic [dataPkg::wordWidth-1:0] dstVal; // Always rd

    modport decoder (
        output opAdd, opNot, opLdm, opInc, opDec, opSub,
        output opAnd, opOr, opShl, opShr, opIn,
        output srcVal, dstVal
    );

    modport alu (
        input opAdd, opNot, opLdm, opInc, opDec, opSub,
        input opAnd, opOr, opShl, opShr, opIn,
        input srcVal, dstVal
    );

endinterface

`default_nettype wire

//--- common/regReadIf.sv
// Two register read ports between the decoder and the register file
`default_nettype none

interface regReadIf;

    logic [dataPkg::regAddrWidth-1:0] rdAddr;
    logic [dataPkg::regAddrWidth-1:0] rsAddr;
    logic [dataPkg::wordWidth-1:0]    rdData;
    logic [dataPkg::wordWidth-1:0]    rsData;

    modport reader (
        output rdAddr, rsAddr,
        input  rdData, rsData
    );

    modport file (
        input  rdAddr, rsAddr,
        output rdData, rsData
    );

endinterface

`default_nettype wire

//--- verilog/instrDecoder.sv
// Instruction decoder producing ALU strobes, register addresses and write enables
`default_nettype none

module instrDecoder (
    input  var logic              instrValid,
    input  var isaPkg::instrWord  instr,
    regReadIf.reader              regRd,
    aluCtrlIf.decoder             alu,
    output var logic              regWrite,
    output var logic              outLoad
);

    logic [isaPkg::opcodeWidth-1:0] opcode;
    logic                           useImm;
    logic [dataPkg::wordWidth-1:0]  immExt;

    // Opcode and rd sit at the same bits in both formats
    assign opcode = instr.regFmt.opcode;
    assign immExt = {{(dataPkg::wordWidth - isaPkg::immWidth){1'b0}}, instr.immFmt.imm};

    assign regRd.rdAddr = instr.regFmt.rd;
    assign regRd.rsAddr = instr.regFmt.rs;

    assign alu.dstVal = regRd.rdData;
    assign alu.srcVal = useImm ? immExt : regRd.rsData; // LDM takes the immediate

    always_comb begin
        alu.opAdd = 1'b0;
        alu.opNot = 1'b0;
        alu.opLdm = 1'b0;
        alu.opInc = 1'b0;
        alu.opDec = 1'b0;
        alu.opSub = 1'b0;
        alu.opAnd = 1'b0;
        alu.opOr  = 1'b0;
        alu.opShl = 1'b0;
        alu.opShr = 1'b0;
        alu.opIn  = 1'b0;
        useImm    = 1'b0;
        regWrite  = 1'b0;
        outLoad   = 1'b0;

        if (instrValid) begin
            // Every ALU opcode writes rd back
            regWrite = 1'b1;
            case (opcode)
                isaPkg::opAdd: alu.opAdd = 1'b1;
                isaPkg::opSub: alu.opSub = 1'b1;
                isaPkg::opAnd: alu.opAnd = 1'b1;
                isaPkg::opOr:  alu.opOr  = 1'b1;
                isaPkg::opNot: alu.opNot = 1'b1;
                isaPkg::opInc: alu.opInc = 1'b1;
                isaPkg::opDec: alu.opDec = 1'b1;
                isaPkg::opShl: alu.opShl = 1'b1;
                isaPkg::opShr: alu.opShr = 1'b1;
                isaPkg::opIn:  alu.opIn  = 1'b1;
                isaPkg::opLdm: begin
                    alu.opLdm = 1'b1;
                    useImm    = 1'b1;
                end
                isaPkg::opOut: begin
                    regWrite = 1'b0;
                    outLoad  = 1'b1; // Port takes rd, no register write
                end
                default: regWrite = 1'b0; // NOP and undefined codes
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/regFile.sv
// Eight-entry register file with two combinational reads and one clocked write
`default_nettype none

module regFile (
    input  var logic                             clk,
    input  var logic                             rstN,
    regReadIf.file                               regRd,
    input  var logic                             regWrite,
    input  var logic [dataPkg::regAddrWidth-1:0] writeAddr,
    input  var logic [dataPkg::wordWidth-1:0]    writeData
);

    logic [dataPkg::wordWidth-1:0] regs [dataPkg::regCount];

    // Reads see the value from before this edge
    assign regRd.rdData = regs[regRd.rdAddr];
    assign regRd.rsData = regs[regRd.rsAddr];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < dataPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

`default_nettype wire

//--- alu/aluCore.sv
// Combinational 16-bit ALU that computes the result and the next condition flags
`default_nettype none

module aluCore (
    aluCtrlIf.alu                             alu,
    input  var logic [dataPkg::wordWidth-1:0] inPort,
    input  var logic [dataPkg::flagWidth-1:0] ccrOld,
    output var logic [dataPkg::wordWidth-1:0] aluResult,
    output var logic [dataPkg::flagWidth-1:0] nextFlags
);

    localparam int width      = dataPkg::wordWidth;
    localparam int shiftWidth = $clog2(width);

    localparam logic [width-1:0] oneVal = 1;

    logic [width:0]            sum;      // Extra bit is the ADD carry
    logic                      bigShift;
    logic [shiftWidth-1:0]     shiftAmt;
    logic                      flagOp;

    assign sum      = {1'b0, alu.dstVal} + {1'b0, alu.srcVal};
    assign shiftAmt = alu.srcVal[shiftWidth-1:0];

    // Shift by 16 or more clears the word
    assign bigShift = |alu.srcVal[width-1:shiftWidth];

    // Strobes are one-hot, the priority order only matters if that breaks
    always_comb begin
        if (alu.opAdd) begin
            aluResult = sum[width-1:0];
        end else if (alu.opNot) begin
            aluResult = ~alu.dstVal;
        end else if (alu.opLdm) begin
            aluResult = alu.srcVal;
        end else if (alu.opInc) begin
            aluResult = alu.dstVal + oneVal;
        end else if (alu.opDec) begin
            aluResult = alu.dstVal - oneVal;
        end else if (alu.opSub) begin
            aluResult = alu.dstVal - alu.srcVal;
        end else if (alu.opAnd) begin
            aluResult = alu.dstVal & alu.srcVal;
        end else if (alu.opOr) begin
            aluResult = alu.dstVal | alu.srcVal;
        end else if (alu.opShl) begin
            aluResult = bigShift ? '0 : alu.dstVal << shiftAmt;
        end else if (alu.opShr) begin
            aluResult = bigShift ? '0 : alu.dstVal >> shiftAmt;
        end else if (alu.opIn) begin
            aluResult = inPort;
        end else begin
            aluResult = '0;
        end
    end

    // Shifts are left out on purpose and keep the old flags
    assign flagOp = alu.opAdd | alu.opNot | alu.opLdm | alu.opInc | alu.opDec
                  | alu.opSub | alu.opAnd | alu.opOr  | alu.opIn;

    always_comb begin
        if (flagOp) begin
            nextFlags[dataPkg::zeroBit]  = (aluResult == '0);
            nextFlags[dataPkg::negBit]   = aluResult[width-1];
            nextFlags[dataPkg::carryBit] = alu.opAdd & sum[width];
        end else begin
            nextFlags = ccrOld; // NOP, OUT and shifts
        end
    end

endmodule

`default_nettype wire

//--- verilog/statusRegs.sv
// Condition code register, output port register and the writeback report
`default_nettype none

module statusRegs #(
    parameter logic [dataPkg::wordWidth-1:0] outResetValue = '0
) (
    input  var logic                             clk,
    input  var logic                             rstN,
    input  var logic                             instrValid,
    input  var logic [dataPkg::flagWidth-1:0]    nextFlags,
    input  var logic                             outLoad,
    input  var logic [dataPkg::wordWidth-1:0]    outData,
    input  var logic                             regWrite,
    input  var logic [dataPkg::regAddrWidth-1:0] wbAddrIn,
    input  var logic [dataPkg::wordWidth-1:0]    wbDataIn,
    output var logic [dataPkg::flagWidth-1:0]    ccr,
    output var logic [dataPkg::wordWidth-1:0]    outPort,
    output var logic                             wbValid,
    output var logic [dataPkg::regAddrWidth-1:0] wbAddr,
    output var logic [dataPkg::wordWidth-1:0]    wbData
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ccr     <= '0;
            outPort <= outResetValue;
            wbValid <= 1'b0;
        end else begin
            // nextFlags already equals ccr for ops that keep the flags
            if (instrValid) begin
                ccr <= nextFlags;
            end
            if (outLoad) begin
                outPort <= outData;
            end
            wbValid <= regWrite; // High for one cycle per write
        end
    end

    // Report payload holds the last write
    always_ff @(posedge clk) begin
        if (regWrite) begin
            wbAddr <= wbAddrIn;
            wbData <= wbDataIn;
        end
    end

endmodule

`default_nettype wire

//--- verilog/execUnit.sv
// Single-cycle execute unit joining decoder, register file, ALU and status registers
`default_nettype none

module execUnit #(
    parameter logic [dataPkg::wordWidth-1:0] outResetValue = '0
) (
    input  var logic                             clk,
    input  var logic                             rstN,
    input  var logic                             instrValid,
    input  var logic [dataPkg::wordWidth-1:0]    instr,
    input  var logic [dataPkg::wordWidth-1:0]    inPort,
    output var logic [dataPkg::wordWidth-1:0]    outPort,
    output var logic [dataPkg::flagWidth-1:0]    flags,
    output var logic                             wbValid,
    output var logic [dataPkg::regAddrWidth-1:0] wbAddr,
    output var logic [dataPkg::wordWidth-1:0]    wbData
);

    aluCtrlIf aluIf ();
    regReadIf regIf ();

    logic                          regWrite;
    logic                          outLoad;
    logic [dataPkg::wordWidth-1:0] aluResult;
    logic [dataPkg::flagWidth-1:0] nextFlags;

    instrDecoder decoder (
        .instrValid (instrValid),
        .instr      (instr),
        .regRd      (regIf.reader),
        .alu        (aluIf.decoder),
        .regWrite   (regWrite),
        .outLoad    (outLoad)
    );

    regFile regs (
        .clk       (clk),
        .rstN      (rstN),
        .regRd     (regIf.file),
        .regWrite  (regWrite),
        .writeAddr (regIf.rdAddr), // Result always goes to rd
        .writeData (aluResult)
    );

    aluCore alu (
        .alu       (aluIf.alu),
        .inPort    (inPort),
        .ccrOld    (flags),
        .aluResult (aluResult),
        .nextFlags (nextFlags)
    );

    statusRegs #(
        .outResetValue (outResetValue)
    ) status (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .nextFlags  (nextFlags),
        .outLoad    (outLoad),
        .outData    (aluIf.dstVal), // OUT sends rd to the port
        .regWrite   (regWrite),
        .wbAddrIn   (regIf.rdAddr),
        .wbDataIn   (aluResult),
        .ccr        (flags),
        .outPort    (outPort),
        .wbValid    (wbValid),
        .wbAddr     (wbAddr),
        .wbData     (wbData)
    );

endmodule

`default_nettype wire

//--- bench/execUnitTb.sv
// Directed testbench for the execute unit with a register, flag and port model
`default_nettype none

module execUnitTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [15:0] outInit    = 16'hA5C3;
    localparam int          resetLimit = 20; // Cycles allowed for reset release
    localparam logic [4:0]  opUndef    = 5'd20;

    logic        clk;
    logic        rstN;
    logic        instrValid;
    logic [15:0] instr;
    logic [15:0] inPort;
    logic [15:0] outPort;
    logic [2:0]  flags;
    logic        wbValid;
    logic [2:0]  wbAddr;
    logic [15:0] wbData;

    // Reference model state
    logic [15:0] modelRegs [8];
    logic [2:0]  expFlags;
    logic [15:0] expOut;
    logic        expWbValid;
    logic [2:0]  expWbAddr;
    logic [15:0] expWbData;

    execUnit #(
        .outResetValue (outInit)
    ) DUT (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .inPort     (inPort),
        .outPort    (outPort),
        .flags      (flags),
        .wbValid    (wbValid),
        .wbAddr     (wbAddr),
        .wbData     (wbData)
    );

    always #4 clk = ~clk;

    // Reset held for three cycles, released on a falling edge
    initial begin
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

    function automatic logic [15:0] regInstr(input logic [4:0] op, input logic [2:0] rd,
                                             input logic [2:0] rs);
        regInstr = {op, rd, rs, 5'b0};
    endfunction

    function automatic logic [15:0] immInstr(input logic [4:0] op, input logic [2:0] rd,
                                             input logic [7:0] imm);
        immInstr = {op, rd, imm};
    endfunction

    // One instruction applied to the model before the clock edge
    function automatic void modelStep(input logic [15:0] word, input logic valid,
                                      input logic [15:0] port);
        logic [4:0]  op;
        logic [2:0]  rd;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic        carry;
        logic        writes;
        logic        setsFlags;
        op         = word[15:11];
        rd         = word[10:8];
        a          = modelRegs[rd];
        b          = modelRegs[word[7:5]];
        res        = '0;
        carry      = 1'b0;
        writes     = 1'b1;
        setsFlags  = 1'b1;
        expWbValid = 1'b0;
        case (op)
            isaPkg::opAdd: {carry, res} = a + b;
            isaPkg::opSub: res = a - b;
            isaPkg::opAnd: res = a & b;
            isaPkg::opOr:  res = a | b;
            isaPkg::opNot: res = ~a;
            isaPkg::opInc: res = a + 16'd1;
            isaPkg::opDec: res = a - 16'd1;
            isaPkg::opLdm: res = {8'h00, word[7:0]};
            isaPkg::opIn:  res = port;
            isaPkg::opShl: begin
                res       = (b >= 16) ? 16'h0 : a << b[3:0];
                setsFlags = 1'b0;
            end
            isaPkg::opShr: begin
                res       = (b >= 16) ? 16'h0 : a >> b[3:0];
                setsFlags = 1'b0;
            end
            isaPkg::opOut: begin
                if (valid) expOut = a;
                writes    = 1'b0;
                setsFlags = 1'b0;
            end
            default: begin // NOP and undefined codes
                writes    = 1'b0;
                setsFlags = 1'b0;
            end
        endcase
        if (valid && setsFlags) begin
            expFlags[dataPkg::zeroBit]  = (res == 16'h0);
            expFlags[dataPkg::negBit]   = res[15];
            expFlags[dataPkg::carryBit] = carry;
        end
        if (valid && writes) begin
            modelRegs[rd] = res;
            expWbValid    = 1'b1;
            expWbAddr     = rd;
            expWbData     = res;
        end
    endfunction

    task automatic checkValue(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h got %h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic waitReset;
        int cycles;
        cycles = 0;
        while (!rstN && cycles < resetLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (!rstN) begin
            $display("Reset was not released within %0d cycles", resetLimit);
            $display("Verification failed");
            $fatal(1, "Reset timeout");
        end
    endtask

    // Drive on the falling edge, check one cycle later on the next falling edge
    task automatic issue(input logic [15:0] word, input logic valid);
        logic [15:0] port;
        port       = 16'($urandom);
        instr      = word;
        instrValid = valid;
        inPort     = port;
        modelStep(word, valid, port);
        @(posedge clk);
        @(negedge clk);
        instrValid = 1'b0;
        checkValue("wbValid", 16'(expWbValid), 16'(wbValid));
        if (expWbValid) begin
            checkValue("wbAddr", 16'(expWbAddr), 16'(wbAddr));
            checkValue("wbData", expWbData, wbData);
        end
        checkValue("flags", 16'(expFlags), 16'(flags));
        checkValue("outPort", expOut, outPort);
    endtask

    task automatic resetState;
        checkValue("flags", 16'h0, 16'(flags));
        checkValue("wbValid", 16'h0, 16'(wbValid));
        checkValue("outPort", outInit, outPort);
    endtask

    task automatic loadAllRegs;
        issue(immInstr(isaPkg::opLdm, 3'd0, 8'h00), 1'b1); // Zero sets Z
        for (int i = 0; i < 8; i++) begin
            issue(immInstr(isaPkg::opLdm, 3'(i), 8'($urandom)), 1'b1);
        end
    endtask

    task automatic arithOps;
        logic [4:0] ops [7];
        ops = '{isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd, isaPkg::opOr,
                isaPkg::opNot, isaPkg::opInc, isaPkg::opDec};
        repeat (40) begin
            issue(regInstr(ops[$urandom % 7], 3'($urandom), 3'($urandom)), 1'b1);
        end
        // 0xFFFF plus one carries out to zero
        issue(immInstr(isaPkg::opLdm, 3'd4, 8'h00), 1'b1);
        issue(regInstr(isaPkg::opDec, 3'd4, 3'd0), 1'b1);
        issue(immInstr(isaPkg::opLdm, 3'd5, 8'h01), 1'b1);
        issue(regInstr(isaPkg::opAdd, 3'd4, 3'd5), 1'b1);
        issue(regInstr(isaPkg::opSub, 3'd6, 3'd6), 1'b1); // Zero result
    endtask

    task automatic shiftOps;
        logic [2:0] amtRegs [4];
        amtRegs = '{3'd1, 3'd2, 3'd3, 3'd4};
        issue(immInstr(isaPkg::opLdm, 3'd1, 8'd0), 1'b1);
        issue(immInstr(isaPkg::opLdm, 3'd2, 8'd15), 1'b1);
        issue(immInstr(isaPkg::opLdm, 3'd3, 8'd16), 1'b1);
        issue(immInstr(isaPkg::opLdm, 3'd4, 8'd200), 1'b1);
        foreach (amtRegs[i]) begin
            issue(immInstr(isaPkg::opLdm, 3'd5, 8'h00), 1'b1);
            issue(immInstr(isaPkg::opLdm, 3'd6, 8'h00), 1'b1);
            issue(regInstr(isaPkg::opDec, 3'd5, 3'd0), 1'b1);
            issue(regInstr(isaPkg::opDec, 3'd6, 3'd0), 1'b1);
            issue(regInstr(isaPkg::opAdd, 3'd5, 3'd6), 1'b1); // C and N set before the shifts
            issue(regInstr(isaPkg::opShl, 3'd6, amtRegs[i]), 1'b1);
            issue(regInstr(isaPkg::opShr, 3'd5, amtRegs[i]), 1'b1);
            issue(immInstr(isaPkg::opLdm, 3'd7, 8'($urandom)), 1'b1);
            issue(regInstr(isaPkg::opShl, 3'd7, amtRegs[i]), 1'b1);
        end
    endtask

    task automatic portOps;
        issue(regInstr(isaPkg::opIn, 3'd2, 3'd0), 1'b1);
        issue(regInstr(isaPkg::opOut, 3'd2, 3'd0), 1'b1);
        issue(regInstr(isaPkg::opIn, 3'd5, 3'd0), 1'b1);
        issue(regInstr(isaPkg::opOut, 3'($urandom), 3'd0), 1'b1);
    endtask

    task automatic idleAndChained;
        issue(regInstr(isaPkg::opNop, 3'd3, 3'd1), 1'b1);
        issue(immInstr(opUndef, 3'd2, 8'($urandom)), 1'b1);
        issue(regInstr(isaPkg::opAdd, 3'd1, 3'd2), 1'b0); // Not qualified
        issue(regInstr(isaPkg::opOut, 3'd1, 3'd0), 1'b0);
        issue(immInstr(isaPkg::opLdm, 3'd0, 8'h7F), 1'b1);
        issue(regInstr(isaPkg::opInc, 3'd0, 3'd0), 1'b1);
        issue(regInstr(isaPkg::opAdd, 3'd1, 3'd0), 1'b1);
        issue(regInstr(isaPkg::opSub, 3'd0, 3'd1), 1'b1);
        issue(regInstr(isaPkg::opOut, 3'd0, 3'd0), 1'b1);
    endtask

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        inPort     = '0;
        void'($urandom(32'h6dd));
        foreach (modelRegs[i]) modelRegs[i] = '0;
        expFlags   = '0;
        expOut     = outInit;
        expWbValid = 1'b0;
        expWbAddr  = '0;
        expWbData  = '0;
        waitReset();
        resetState();
        loadAllRegs();
        arithOps();
        shiftOps();
        portOps();
        idleAndChained();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
common/dataPkg.sv
common/isaPkg.sv
common/aluCtrlIf.sv
common/regReadIf.sv
verilog/instrDecoder.sv
verilog/regFile.sv
alu/aluCore.sv
verilog/statusRegs.sv
verilog/execUnit.sv
bench/execUnitTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing
LINTFLAGS = --lint-only --timing
TOP       = execUnitTb
FILELIST  = src.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

# Exit status of the simulator is ignored, the log decides
run: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
